// File: logic/tile_pkg.sv
`default_nettype none

package tile_pkg;

  localparam int coord_width = 4;
  localparam int data_width  = 32;

  // packet opcodes
  localparam int op_width = 2;
  localparam logic [op_width-1:0] op_read_acc   = 2'd0;
  localparam logic [op_width-1:0] op_clear_acc  = 2'd1;
  localparam logic [op_width-1:0] op_reply      = 2'd2;
  localparam logic [op_width-1:0] op_write_data = 2'd3; // routed, socket drops it

  // {dst_x, dst_y, src_x, src_y, op, data}, msb first
  localparam int pkt_width = 4 * coord_width + op_width + data_width;

  localparam int data_lsb  = 0;
  localparam int op_lsb    = data_lsb + data_width;
  localparam int src_y_lsb = op_lsb + op_width;
  localparam int src_x_lsb = src_y_lsb + coord_width;
  localparam int dst_y_lsb = src_x_lsb + coord_width;
  localparam int dst_x_lsb = dst_y_lsb + coord_width;

  // router port indices
  localparam int dir_p = 0;
  localparam int dir_w = 1;
  localparam int dir_e = 2;
  localparam int dir_n = 3;
  localparam int dir_s = 4;
  localparam int num_ports = 5;

  localparam logic [3:0] ctl_clear = 4'h1; // zero the accumulator

  // systolic message, kind bit picks the view
  typedef union packed {
    struct packed {
      logic                  kind;    // 0
      logic [3:0]            unused;
      logic [data_width-1:0] operand;
    } data;
    struct packed {
      logic                  kind;    // 1
      logic [3:0]            code;
      logic [data_width-1:0] tag;
    } ctl;
  } sys_msg_u;

endpackage

`default_nettype wire

// File: logic/mesh_input_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_input_fifo #(
  parameter int fifo_depth_p = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [tile_pkg::pkt_width-1:0] data_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic [tile_pkg::pkt_width-1:0] data_o,
  output logic                          valid_o,
  input  logic                          yumi_i
);

  localparam int ptr_w = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int cnt_w = $clog2(fifo_depth_p + 1);

  logic [tile_pkg::pkt_width-1:0] mem [fifo_depth_p];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic empty, push, pop;

  assign empty   = (count_q == '0);
  assign ready_o = (count_q != cnt_w'(fifo_depth_p));
  assign valid_o = !empty || valid_i;           // flow through when empty
  assign data_o  = empty ? data_i : mem[rd_ptr_q];

  // a flit taken in the same cycle it arrives never lands in memory
  assign push = valid_i && ready_o && !(empty && yumi_i);
  assign pop  = yumi_i && !empty;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == ptr_w'(fifo_depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == ptr_w'(fifo_depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= data_i;
  end

  // the router only takes what the buffer offers
  a_yumi_valid: assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> valid_o);

endmodule

`default_nettype wire

// File: logic/mesh_node.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_node #(
  parameter int fifo_depth_p = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic [tile_pkg::coord_width-1:0] my_x_i,
  input  logic [tile_pkg::coord_width-1:0] my_y_i,
  input  logic [tile_pkg::dir_s:tile_pkg::dir_w][tile_pkg::pkt_width-1:0] link_in_data_i,
  input  logic [tile_pkg::dir_s:tile_pkg::dir_w] link_in_valid_i,
  output logic [tile_pkg::dir_s:tile_pkg::dir_w] link_in_ready_o,
  output logic [tile_pkg::dir_s:tile_pkg::dir_w][tile_pkg::pkt_width-1:0] link_out_data_o,
  output logic [tile_pkg::dir_s:tile_pkg::dir_w] link_out_valid_o,
  input  logic [tile_pkg::dir_s:tile_pkg::dir_w] link_out_ready_i,
  input  logic [tile_pkg::pkt_width-1:0] proc_in_data_i,
  input  logic                           proc_in_valid_i,
  output logic                           proc_in_ready_o,
  output logic [tile_pkg::pkt_width-1:0] proc_out_data_o,
  output logic                           proc_out_valid_o,
  input  logic                           proc_out_ready_i
);

  localparam int np = tile_pkg::num_ports;
  localparam int pw = tile_pkg::pkt_width;
  localparam logic [np-1:0] one_lp = 1;

  logic [np-1:0][pw-1:0] in_data, fifo_data, win_data, out_data_q;
  logic [np-1:0] in_valid, in_ready, fifo_valid, yumi;
  logic [np-1:0] out_valid_q, out_ready, out_free;
  logic [np-1:0][np-1:0] req;    // [input][output]
  logic [np-1:0][np-1:0] grant;  // [output][input]
  logic [np-1:0][2:0] last_q, win_idx;

  // x first, then y, then home
  function automatic logic [2:0] xy_dir(input logic [pw-1:0] pkt,
                                        input logic [tile_pkg::coord_width-1:0] x,
                                        input logic [tile_pkg::coord_width-1:0] y);
    logic [tile_pkg::coord_width-1:0] dx, dy;
    dx = pkt[tile_pkg::dst_x_lsb +: tile_pkg::coord_width];
    dy = pkt[tile_pkg::dst_y_lsb +: tile_pkg::coord_width];
    if (dx > x) return 3'(tile_pkg::dir_e);
    if (dx < x) return 3'(tile_pkg::dir_w);
    if (dy > y) return 3'(tile_pkg::dir_s);
    if (dy < y) return 3'(tile_pkg::dir_n);
    return 3'(tile_pkg::dir_p);
  endfunction

  assign in_data  = {link_in_data_i, proc_in_data_i};
  assign in_valid = {link_in_valid_i, proc_in_valid_i};
  assign {link_in_ready_o, proc_in_ready_o} = in_ready;
  assign out_ready = {link_out_ready_i, proc_out_ready_i};

  for (genvar i = 0; i < np; i++) begin : g_in
    mesh_input_fifo #(.fifo_depth_p(fifo_depth_p)) i_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (in_data[i]),
      .valid_i (in_valid[i]),
      .ready_o (in_ready[i]),
      .data_o  (fifo_data[i]),
      .valid_o (fifo_valid[i]),
      .yumi_i  (yumi[i])
    );
    assign req[i] = fifo_valid[i] ? (one_lp << xy_dir(fifo_data[i], my_x_i, my_y_i)) : '0;
  end

  assign out_free = ~out_valid_q | out_ready;

  // round robin, search starts after last winner
  always_comb begin
    int idx;
    grant    = '0;
    yumi     = '0;
    win_data = '0;
    win_idx  = '0;
    for (int o = 0; o < np; o++) begin
      for (int k = 1; k <= np; k++) begin
        idx = (int'(last_q[o]) + k) % np;
        if (out_free[o] && req[idx][o] && grant[o] == '0) begin
          grant[o][idx] = 1'b1;
          yumi[idx]     = 1'b1;
          win_data[o]   = fifo_data[idx];
          win_idx[o]    = 3'(idx);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= '0;
      last_q      <= '0;
    end else begin
      for (int o = 0; o < np; o++) begin
        if (grant[o] != '0) begin
          out_valid_q[o] <= 1'b1;
          last_q[o]      <= win_idx[o];
        end else if (out_ready[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < np; o++) begin
      if (grant[o] != '0) out_data_q[o] <= win_data[o];
    end
  end

  assign proc_out_data_o  = out_data_q[tile_pkg::dir_p];
  assign proc_out_valid_o = out_valid_q[tile_pkg::dir_p];
  assign link_out_data_o  = out_data_q[tile_pkg::dir_s:tile_pkg::dir_w];
  assign link_out_valid_o = out_valid_q[tile_pkg::dir_s:tile_pkg::dir_w];

  for (genvar o = 0; o < np; o++) begin : g_chk
    logic [np-1:0] asked;  // inputs whose head wants this output
    for (genvar i = 0; i < np; i++) begin : g_ask
      assign asked[i] = req[i][o];
    end
    // free output with a request picks exactly one input, otherwise none
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_free[o] && asked != '0) ? $onehot(grant[o]) : (grant[o] == '0));
  end

endmodule

`default_nettype wire

// File: logic/systolic_pe.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_pe (
  input  logic                clk_i,
  input  logic                rst_i,
  input  tile_pkg::sys_msg_u  in_row_msg_i,
  input  logic                in_row_valid_i,
  output logic                in_row_ready_o,
  input  tile_pkg::sys_msg_u  in_col_msg_i,
  input  logic                in_col_valid_i,
  output logic                in_col_ready_o,
  output tile_pkg::sys_msg_u  out_row_msg_o,
  output logic                out_row_valid_o,
  input  logic                out_row_ready_i,
  output tile_pkg::sys_msg_u  out_col_msg_o,
  output logic                out_col_valid_o,
  input  logic                out_col_ready_i,
  input  logic                clear_i,
  output logic [tile_pkg::data_width-1:0] acc_o
);

  logic row_is_ctl, row_free, col_free;
  logic fire_ctl, fire_data, do_clear;
  logic [tile_pkg::data_width-1:0] acc_q, product;

  assign row_is_ctl = in_row_msg_i.ctl.kind;
  assign row_free   = !out_row_valid_o || out_row_ready_i;
  assign col_free   = !out_col_valid_o || out_col_ready_i;

  // control needs only the row side, data needs both
  assign fire_ctl  = in_row_valid_i && row_is_ctl && row_free;
  assign fire_data = in_row_valid_i && !row_is_ctl && in_col_valid_i && row_free && col_free;

  assign in_row_ready_o = row_is_ctl ? row_free : (in_col_valid_i && row_free && col_free);
  assign in_col_ready_o = in_row_valid_i && !row_is_ctl && row_free && col_free;

  assign product  = in_row_msg_i.data.operand * in_col_msg_i.data.operand; // low 32 bits
  assign do_clear = clear_i || (fire_ctl && in_row_msg_i.ctl.code == tile_pkg::ctl_clear);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_q <= '0;
    end else begin
      acc_q <= (do_clear ? '0 : acc_q) + (fire_data ? product : '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_row_valid_o <= 1'b0;
      out_col_valid_o <= 1'b0;
    end else begin
      if (fire_ctl || fire_data) out_row_valid_o <= 1'b1;
      else if (out_row_ready_i) out_row_valid_o <= 1'b0;
      if (fire_data) out_col_valid_o <= 1'b1;
      else if (out_col_ready_i) out_col_valid_o <= 1'b0;
    end
  end

  // forwarding regs, operands pass unchanged
  always_ff @(posedge clk_i) begin
    if (fire_ctl || fire_data) out_row_msg_o <= in_row_msg_i;
    if (fire_data) out_col_msg_o <= in_col_msg_i;
  end

  assign acc_o = acc_q;

  a_row_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_row_valid_o && !out_row_ready_i |=> out_row_valid_o && $stable(out_row_msg_o));
  a_col_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_col_valid_o && !out_col_ready_i |=> out_col_valid_o && $stable(out_col_msg_o));

endmodule

`default_nettype wire

// File: logic/proc_socket.sv
`timescale 1ns/1ps
`default_nettype none

module proc_socket (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [tile_pkg::coord_width-1:0] my_x_i,
  input  logic [tile_pkg::coord_width-1:0] my_y_i,
  input  logic [tile_pkg::pkt_width-1:0] pkt_data_i,
  input  logic                           pkt_valid_i,
  output logic                           pkt_ready_o,
  output logic [tile_pkg::pkt_width-1:0] pkt_data_o,
  output logic                           pkt_valid_o,
  input  logic                           pkt_ready_i,
  input  tile_pkg::sys_msg_u             in_row_msg_i,
  input  logic                           in_row_valid_i,
  output logic                           in_row_ready_o,
  input  tile_pkg::sys_msg_u             in_col_msg_i,
  input  logic                           in_col_valid_i,
  output logic                           in_col_ready_o,
  output tile_pkg::sys_msg_u             out_row_msg_o,
  output logic                           out_row_valid_o,
  input  logic                           out_row_ready_i,
  output tile_pkg::sys_msg_u             out_col_msg_o,
  output logic                           out_col_valid_o,
  input  logic                           out_col_ready_i
);

  logic [tile_pkg::op_width-1:0] op;
  logic accept, is_read, is_clear;
  logic [tile_pkg::data_width-1:0] acc;
  logic [tile_pkg::pkt_width-1:0] reply_d;

  assign op          = pkt_data_i[tile_pkg::op_lsb +: tile_pkg::op_width];
  assign pkt_ready_o = !pkt_valid_o || pkt_ready_i; // stall behind a pending reply
  assign accept      = pkt_valid_i && pkt_ready_o;
  assign is_read     = accept && (op == tile_pkg::op_read_acc);
  assign is_clear    = accept && (op == tile_pkg::op_clear_acc);

  // reply goes back to the requester
  always_comb begin
    reply_d = '0;
    reply_d[tile_pkg::dst_x_lsb +: tile_pkg::coord_width] =
      pkt_data_i[tile_pkg::src_x_lsb +: tile_pkg::coord_width];
    reply_d[tile_pkg::dst_y_lsb +: tile_pkg::coord_width] =
      pkt_data_i[tile_pkg::src_y_lsb +: tile_pkg::coord_width];
    reply_d[tile_pkg::src_x_lsb +: tile_pkg::coord_width] = my_x_i;
    reply_d[tile_pkg::src_y_lsb +: tile_pkg::coord_width] = my_y_i;
    reply_d[tile_pkg::op_lsb +: tile_pkg::op_width]       = tile_pkg::op_reply;
    reply_d[tile_pkg::data_lsb +: tile_pkg::data_width]   = acc;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pkt_valid_o <= 1'b0;
    end else if (is_read) begin
      pkt_valid_o <= 1'b1;
    end else if (pkt_ready_i) begin
      pkt_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_read) pkt_data_o <= reply_d;
  end

  systolic_pe i_pe (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .in_row_msg_i    (in_row_msg_i),
    .in_row_valid_i  (in_row_valid_i),
    .in_row_ready_o  (in_row_ready_o),
    .in_col_msg_i    (in_col_msg_i),
    .in_col_valid_i  (in_col_valid_i),
    .in_col_ready_o  (in_col_ready_o),
    .out_row_msg_o   (out_row_msg_o),
    .out_row_valid_o (out_row_valid_o),
    .out_row_ready_i (out_row_ready_i),
    .out_col_msg_o   (out_col_msg_o),
    .out_col_valid_o (out_col_valid_o),
    .out_col_ready_i (out_col_ready_i),
    .clear_i         (is_clear),
    .acc_o           (acc)
  );

endmodule

`default_nettype wire

// File: logic/manycore_tile.sv
`timescale 1ns/1ps
`default_nettype none

module manycore_tile #(
  parameter int fifo_depth_p = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic [tile_pkg::coord_width-1:0] my_x_i,
  input  logic [tile_pkg::coord_width-1:0] my_y_i,
  input  logic [tile_pkg::dir_s:tile_pkg::dir_w][tile_pkg::pkt_width-1:0] link_in_data_i,
  input  logic [tile_pkg::dir_s:tile_pkg::dir_w] link_in_valid_i,
  output logic [tile_pkg::dir_s:tile_pkg::dir_w] link_in_ready_o,
  output logic [tile_pkg::dir_s:tile_pkg::dir_w][tile_pkg::pkt_width-1:0] link_out_data_o,
  output logic [tile_pkg::dir_s:tile_pkg::dir_w] link_out_valid_o,
  input  logic [tile_pkg::dir_s:tile_pkg::dir_w] link_out_ready_i,
  input  tile_pkg::sys_msg_u in_row_msg_i,
  input  logic               in_row_valid_i,
  output logic               in_row_ready_o,
  input  tile_pkg::sys_msg_u in_col_msg_i,
  input  logic               in_col_valid_i,
  output logic               in_col_ready_o,
  output tile_pkg::sys_msg_u out_row_msg_o,
  output logic               out_row_valid_o,
  input  logic               out_row_ready_i,
  output tile_pkg::sys_msg_u out_col_msg_o,
  output logic               out_col_valid_o,
  input  logic               out_col_ready_i
);

  logic rst_q;
  logic [tile_pkg::pkt_width-1:0] proc_out_data, proc_in_data;
  logic proc_out_valid, proc_out_ready, proc_in_valid, proc_in_ready;

  // reset travels far across the array, so each tile retimes it
  always_ff @(posedge clk_i) begin
    rst_q <= rst_i;
  end

  mesh_node #(.fifo_depth_p(fifo_depth_p)) i_node (
    .clk_i            (clk_i),
    .rst_i            (rst_q),
    .my_x_i           (my_x_i),
    .my_y_i           (my_y_i),
    .link_in_data_i   (link_in_data_i),
    .link_in_valid_i  (link_in_valid_i),
    .link_in_ready_o  (link_in_ready_o),
    .link_out_data_o  (link_out_data_o),
    .link_out_valid_o (link_out_valid_o),
    .link_out_ready_i (link_out_ready_i),
    .proc_in_data_i   (proc_in_data),
    .proc_in_valid_i  (proc_in_valid),
    .proc_in_ready_o  (proc_in_ready),
    .proc_out_data_o  (proc_out_data),
    .proc_out_valid_o (proc_out_valid),
    .proc_out_ready_i (proc_out_ready)
  );

  proc_socket i_socket (
    .clk_i           (clk_i),
    .rst_i           (rst_q),
    .my_x_i          (my_x_i),
    .my_y_i          (my_y_i),
    .pkt_data_i      (proc_out_data),
    .pkt_valid_i     (proc_out_valid),
    .pkt_ready_o     (proc_out_ready),
    .pkt_data_o      (proc_in_data),
    .pkt_valid_o     (proc_in_valid),
    .pkt_ready_i     (proc_in_ready),
    .in_row_msg_i    (in_row_msg_i),
    .in_row_valid_i  (in_row_valid_i),
    .in_row_ready_o  (in_row_ready_o),
    .in_col_msg_i    (in_col_msg_i),
    .in_col_valid_i  (in_col_valid_i),
    .in_col_ready_o  (in_col_ready_o),
    .out_row_msg_o   (out_row_msg_o),
    .out_row_valid_o (out_row_valid_o),
    .out_row_ready_i (out_row_ready_i),
    .out_col_msg_o   (out_col_msg_o),
    .out_col_valid_o (out_col_valid_o),
    .out_col_ready_i (out_col_ready_i)
  );

endmodule

`default_nettype wire

// File: verification/tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tile_tb;

  localparam int pw = tile_pkg::pkt_width;
  localparam int mw = 37;                    // systolic message width
  localparam int n_tests = 20;
  localparam int timeout_cycles = 64 * (n_tests + 1);

  localparam int k_mesh = 0;                 // packet through the router
  localparam int k_pair = 1;
  localparam int k_sclr = 2;
  localparam int k_read = 3;
  localparam int k_cpkt = 4;                 // clear packet to the socket

  localparam int d_w = 1;
  localparam int d_e = 2;
  localparam int d_n = 3;
  localparam int d_s = 4;

  logic clk, rst;
  logic [3:0] my_x, my_y;
  logic [4:1][pw-1:0] link_in_data, link_out_data;
  logic [4:1] link_in_valid, link_in_ready, link_out_valid, link_out_ready;
  logic [mw-1:0] in_row_msg, in_col_msg, out_row_msg, out_col_msg;
  logic in_row_valid, in_row_ready, in_col_valid, in_col_ready;
  logic out_row_valid, out_row_ready, out_col_valid, out_col_ready;

  // stimulus table
  int         t_kind  [n_tests];
  int         t_in    [n_tests];   // input link
  logic [3:0] t_dx    [n_tests];
  logic [3:0] t_dy    [n_tests];
  int         t_count [n_tests];   // messages per entry
  bit         t_stall [n_tests];
  int         t_out   [n_tests];   // expected output link

  logic [pw-1:0] exp_link_q [4:1][$];
  logic [mw-1:0] exp_row_q [$];
  logic [mw-1:0] exp_col_q [$];
  logic [31:0] acc_model, data_lfsr, stall_lfsr;
  int errors, failed;
  int cycles = 0;
  bit mon_en, stall_en;

  manycore_tile #(.fifo_depth_p(2)) i_dut (
    .clk_i            (clk),
    .rst_i            (rst),
    .my_x_i           (my_x),
    .my_y_i           (my_y),
    .link_in_data_i   (link_in_data),
    .link_in_valid_i  (link_in_valid),
    .link_in_ready_o  (link_in_ready),
    .link_out_data_o  (link_out_data),
    .link_out_valid_o (link_out_valid),
    .link_out_ready_i (link_out_ready),
    .in_row_msg_i     (in_row_msg),
    .in_row_valid_i   (in_row_valid),
    .in_row_ready_o   (in_row_ready),
    .in_col_msg_i     (in_col_msg),
    .in_col_valid_i   (in_col_valid),
    .in_col_ready_o   (in_col_ready),
    .out_row_msg_o    (out_row_msg),
    .out_row_valid_o  (out_row_valid),
    .out_row_ready_i  (out_row_ready),
    .out_col_msg_o    (out_col_msg),
    .out_col_valid_o  (out_col_valid),
    .out_col_ready_i  (out_col_ready)
  );

  always #5 clk = ~clk;

  // galois form, taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_word(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w = {w[30:0], data_lfsr[0]};
      data_lfsr = lfsr_step(data_lfsr);
    end
    return w;
  endfunction

  function automatic logic stall_bit();
    logic b;
    b = stall_lfsr[0];
    stall_lfsr = lfsr_step(stall_lfsr);
    return b;
  endfunction

  function automatic logic [pw-1:0] make_pkt(input logic [3:0] dx, dy, sx, sy,
                                             input logic [1:0] op, input logic [31:0] data);
    return {dx, dy, sx, sy, op, data};
  endfunction

  function automatic string dir_name(input int d);
    case (d)
      d_w: return "W";
      d_e: return "E";
      d_n: return "N";
      default: return "S";
    endcase
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      k_mesh: return "mesh send";
      k_pair: return "systolic pair";
      k_sclr: return "systolic clear";
      k_read: return "acc read";
      default: return "clear packet";
    endcase
  endfunction

  function automatic int pending();
    return exp_row_q.size() + exp_col_q.size() + exp_link_q[1].size()
         + exp_link_q[2].size() + exp_link_q[3].size() + exp_link_q[4].size();
  endfunction

  task automatic set_entry(input int i, input int kind, input int in_d,
                           input logic [3:0] dx, input logic [3:0] dy,
                           input int count, input bit stall, input int out_d);
    t_kind[i]  = kind;
    t_in[i]    = in_d;
    t_dx[i]    = dx;
    t_dy[i]    = dy;
    t_count[i] = count;
    t_stall[i] = stall;
    t_out[i]   = out_d;
  endtask

  task automatic check_link(input int d, input logic [pw-1:0] got);
    logic [pw-1:0] want;
    assert (exp_link_q[d].size() > 0) else begin
      $display("%0t: packet left on link %s when none was expected", $time, dir_name(d));
      errors++;
    end
    if (exp_link_q[d].size() > 0) begin
      want = exp_link_q[d].pop_front();
      assert (got == want) else begin
        $display("MISMATCH at %0t: link_out_data_o[%s] got %h expected %h",
                 $time, dir_name(d), got, want);
        errors++;
      end
    end
  endtask

  task automatic check_sys(input bit col, input logic [mw-1:0] got);
    logic [mw-1:0] want;
    int n;
    n = col ? exp_col_q.size() : exp_row_q.size();
    assert (n > 0) else begin
      $display("%0t: message left on %s when none was expected", $time,
               col ? "out_col" : "out_row");
      errors++;
    end
    if (n > 0) begin
      if (col) want = exp_col_q.pop_front();
      else want = exp_row_q.pop_front();
      assert (got == want) else begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time,
                 col ? "out_col_msg_o" : "out_row_msg_o", got, want);
        errors++;
      end
    end
  endtask

  // transfer happens at the next rising edge, values are settled here
  always @(negedge clk) begin
    if (mon_en) begin
      for (int d = 1; d <= 4; d++) begin
        if (link_out_valid[d] && link_out_ready[d]) check_link(d, link_out_data[d]);
      end
      if (out_row_valid && out_row_ready) check_sys(1'b0, out_row_msg);
      if (out_col_valid && out_col_ready) check_sys(1'b1, out_col_msg);
    end
  end

  always @(posedge clk) begin
    #1;
    if (stall_en) begin
      for (int d = 1; d <= 4; d++) link_out_ready[d] = stall_bit();
      out_row_ready = stall_bit();
      out_col_ready = stall_bit();
    end else begin
      link_out_ready = '1;
      out_row_ready  = 1'b1;
      out_col_ready  = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic send_link(input int d, input logic [pw-1:0] pkt);
    logic taken;
    link_in_data[d]  = pkt;
    link_in_valid[d] = 1'b1;
    do begin
      @(negedge clk);
      taken = link_in_ready[d];
      @(posedge clk);
      #1;
    end while (!taken);
    link_in_valid[d] = 1'b0;
  endtask

  task automatic send_sys(input logic [mw-1:0] r, input logic [mw-1:0] c, input bit with_col);
    bit row_done, col_done;
    row_done     = 1'b0;
    col_done     = !with_col;    // a clear goes without a column operand
    in_row_msg   = r;
    in_col_msg   = c;
    in_row_valid = 1'b1;
    in_col_valid = with_col;
    while (!(row_done && col_done)) begin
      @(negedge clk);
      if (in_row_valid && in_row_ready) row_done = 1'b1;
      if (in_col_valid && in_col_ready) col_done = 1'b1;
      @(posedge clk);
      #1;
      if (row_done) in_row_valid = 1'b0;
      if (col_done) in_col_valid = 1'b0;
    end
  endtask

  task automatic apply_one(input int t);
    logic [pw-1:0] pkt;
    logic [31:0] a, b;
    case (t_kind[t])
      k_mesh: begin
        pkt = make_pkt(t_dx[t], t_dy[t], 4'd2, 4'd3, tile_pkg::op_write_data, rand_word(32));
        exp_link_q[t_out[t]].push_back(pkt);
        send_link(t_in[t], pkt);
      end
      k_pair: begin
        a = rand_word(32);
        b = rand_word(32);
        exp_row_q.push_back({1'b0, 4'h0, a});
        exp_col_q.push_back({1'b0, 4'h0, b});
        acc_model = acc_model + a * b;   // low half of the product
        send_sys({1'b0, 4'h0, a}, {1'b0, 4'h0, b}, 1'b1);
      end
      k_sclr: begin
        a = rand_word(32);
        exp_row_q.push_back({1'b1, tile_pkg::ctl_clear, a});
        acc_model = '0;
        send_sys({1'b1, tile_pkg::ctl_clear, a}, '0, 1'b0);
      end
      k_read: begin
        pkt = make_pkt(t_dx[t], t_dy[t], 4'd0, 4'd1, tile_pkg::op_read_acc, rand_word(32));
        exp_link_q[t_out[t]].push_back(
          make_pkt(4'd0, 4'd1, 4'd1, 4'd1, tile_pkg::op_reply, acc_model));
        send_link(t_in[t], pkt);
      end
      default: begin
        acc_model = '0;
        send_link(t_in[t], make_pkt(t_dx[t], t_dy[t], 4'd0, 4'd1, tile_pkg::op_clear_acc, '0));
      end
    endcase
  endtask

  task automatic wait_drain();
    while (pending() > 0) begin
      @(posedge clk);
      #1;
    end
    assert (link_out_valid == '0 && !out_row_valid && !out_col_valid) else begin
      $display("%0t: an output still offers a message after all expected ones left", $time);
      errors++;
    end
  endtask

  initial begin
    int errs0;
    clk = 1'b0;
    rst = 1'b1;
    my_x = 4'd1;
    my_y = 4'd1;
    link_in_data   = '0;
    link_in_valid  = '0;
    link_out_ready = '1;
    in_row_msg     = '0;
    in_row_valid   = 1'b0;
    in_col_msg     = '0;
    in_col_valid   = 1'b0;
    out_row_ready  = 1'b1;
    out_col_ready  = 1'b1;
    data_lfsr  = 32'h34ab;
    stall_lfsr = 32'h34ab;
    acc_model  = '0;
    errors   = 0;
    failed   = 0;
    mon_en   = 1'b0;
    stall_en = 1'b0;

    set_entry(0,  k_mesh, d_w, 4'd3, 4'd1, 1, 1'b0, d_e);
    set_entry(1,  k_mesh, d_e, 4'd0, 4'd1, 1, 1'b0, d_w);
    set_entry(2,  k_mesh, d_s, 4'd1, 4'd0, 1, 1'b0, d_n);
    set_entry(3,  k_mesh, d_n, 4'd1, 4'd2, 1, 1'b0, d_s);
    set_entry(4,  k_pair, 0,   4'd0, 4'd0, 1, 1'b0, 0);
    set_entry(5,  k_pair, 0,   4'd0, 4'd0, 3, 1'b0, 0);
    set_entry(6,  k_read, d_w, 4'd1, 4'd1, 1, 1'b0, d_w);
    set_entry(7,  k_sclr, 0,   4'd0, 4'd0, 1, 1'b0, 0);
    set_entry(8,  k_read, d_w, 4'd1, 4'd1, 1, 1'b0, d_w);
    set_entry(9,  k_pair, 0,   4'd0, 4'd0, 2, 1'b0, 0);
    set_entry(10, k_read, d_w, 4'd1, 4'd1, 1, 1'b0, d_w);
    set_entry(11, k_cpkt, d_w, 4'd1, 4'd1, 1, 1'b0, 0);
    set_entry(12, k_read, d_w, 4'd1, 4'd1, 1, 1'b0, d_w);
    set_entry(13, k_mesh, d_w, 4'd3, 4'd1, 6, 1'b1, d_e);  // fills the fifo
    set_entry(14, k_mesh, d_n, 4'd1, 4'd2, 5, 1'b1, d_s);
    set_entry(15, k_pair, 0,   4'd0, 4'd0, 6, 1'b1, 0);
    set_entry(16, k_read, d_w, 4'd1, 4'd1, 1, 1'b1, d_w);
    set_entry(17, k_sclr, 0,   4'd0, 4'd0, 1, 1'b1, 0);
    set_entry(18, k_pair, 0,   4'd0, 4'd0, 3, 1'b1, 0);
    set_entry(19, k_read, d_w, 4'd1, 4'd1, 2, 1'b1, d_w);

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);   // tile retimes its reset
    #1;

    errs0 = errors;
    assert (link_out_valid == '0) else begin
      $display("MISMATCH at %0t: link_out_valid_o got %b expected 0000", $time, link_out_valid);
      errors++;
    end
    assert (!out_row_valid) else begin
      $display("MISMATCH at %0t: out_row_valid_o got %b expected 0", $time, out_row_valid);
      errors++;
    end
    assert (!out_col_valid) else begin
      $display("MISMATCH at %0t: out_col_valid_o got %b expected 0", $time, out_col_valid);
      errors++;
    end
    if (errors == errs0) begin
      $display("test 0 reset: ok");
    end else begin
      $display("test 0 reset: failed");
      failed++;
    end
    mon_en = 1'b1;

    for (int t = 0; t < n_tests; t++) begin
      errs0 = errors;
      stall_en = t_stall[t];
      for (int k = 0; k < t_count[t]; k++) apply_one(t);
      wait_drain();
      stall_en = 1'b0;
      if (errors == errs0) begin
        $display("test %0d %s: ok", t + 1, kind_name(t_kind[t]));
      end else begin
        $display("test %0d %s: failed with %0d errors", t + 1, kind_name(t_kind[t]),
                 errors - errs0);
        failed++;
      end
    end

    $display("%0d tests run, %0d failed, %0d errors", n_tests + 1, failed, errors);
    if (failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
logic/tile_pkg.sv
logic/mesh_input_fifo.sv
logic/mesh_node.sv
logic/systolic_pe.sv
logic/proc_socket.sv
logic/manycore_tile.sv
verification/tile_tb.sv

// File: Bender.yml
package:
  name: manycore_tile

sources:
  - logic/tile_pkg.sv
  - logic/mesh_input_fifo.sv
  - logic/mesh_node.sv
  - logic/systolic_pe.sv
  - logic/proc_socket.sv
  - logic/manycore_tile.sv
  - target: test
    files:
      - verification/tile_tb.sv
